// ==== Makefile ====
# Verilator build, run, lint and clean for the line register file

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TOP        ?= tb_rf_subsystem
RTL_TOP    ?= rf_subsystem
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(shell grep -v '^verif/' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/rf_bus_pkg.sv ====
// Wishbone classic request/response structs, idle constants and the move command

package rf_bus_pkg;

    import rf_types_pkg::*;

    // master to slave, classic cycle
    // adr, we and dat stay stable from stb until ack
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        line_t dat;
    } wb_req_t;

    // slave to master
    // dat only valid together with ack on a read
    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_rsp_t;

    // copy count lines from src to dst, ascending
    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        count_t count;
    } move_cmd_t;

    // no cycle in flight
    localparam wb_req_t WB_REQ_IDLE = '{
        cyc: 1'b0,
        stb: 1'b0,
        we:  1'b0,
        adr: '0,
        dat: '0
    };

    // no ack, data held at zero
    localparam wb_rsp_t WB_RSP_IDLE = '{
        ack: 1'b0,
        dat: '0
    };

endpackage

// ==== common/rf_types_pkg.sv ====
// width constants and vector typedefs for lines, addresses and move counts

package rf_types_pkg;

    // one register-file line
    localparam int LINE_W = 64;

    // line address, the memory is addressed per line
    localparam int ADDR_W = 8;

    // move length in lines, 0 to 255
    localparam int COUNT_W = 8;

    // lines reachable with one address
    localparam int ADDR_SPACE = 2 ** ADDR_W;

    // payload of one line
    typedef logic [LINE_W-1:0] line_t;

    // line address, wraps modulo the address space
    typedef logic [ADDR_W-1:0] addr_t;

    // number of lines left or requested in a move
    typedef logic [COUNT_W-1:0] count_t;

endpackage

// ==== hdl/bus_arbiter.sv ====
// two-master round-robin Wishbone classic arbiter in front of the line memory

module bus_arbiter
    import rf_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t host_req,
    input  wb_req_t move_req,
    input  wb_rsp_t ram_rsp,
    output wb_rsp_t host_rsp,
    output wb_rsp_t move_rsp,
    output wb_req_t ram_req
);

    // grant selector: 0 host, 1 move engine
    logic gnt_q;
    logic gnt_d;
    // grant is live and the granted master reaches the RAM
    logic gnt_vld_q;
    logic gnt_vld_d;
    // master that took the last ack, 1 for the move engine
    logic last_q;

    logic host_want;
    logic move_want;
    logic cur_cyc;
    logic free;

    assign host_want = host_req.cyc && host_req.stb;
    assign move_want = move_req.cyc && move_req.stb;

    // the owner keeps the bus for as long as it holds cyc
    assign cur_cyc = gnt_q ? move_req.cyc : host_req.cyc;
    assign free    = !gnt_vld_q || !cur_cyc;

    always_comb begin
        gnt_d     = gnt_q;
        gnt_vld_d = gnt_vld_q;
        if (free) begin
            gnt_vld_d = host_want || move_want;
            if (host_want && move_want) begin
                // contention, the master not served last goes first
                gnt_d = !last_q;
            end else if (move_want) begin
                gnt_d = 1'b1;
            end else if (host_want) begin
                gnt_d = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q     <= 1'b0;
            gnt_vld_q <= 1'b0;
            last_q    <= 1'b1;
        end else begin
            gnt_q     <= gnt_d;
            gnt_vld_q <= gnt_vld_d;
            if (ram_rsp.ack) begin
                last_q <= gnt_q;
            end
        end
    end

    // request path is combinational from the registered grant
    always_comb begin
        ram_req = WB_REQ_IDLE;
        if (gnt_vld_q) begin
            ram_req = gnt_q ? move_req : host_req;
        end
    end

    // ack and read data only reach the granted master
    always_comb begin
        host_rsp = WB_RSP_IDLE;
        move_rsp = WB_RSP_IDLE;
        if (gnt_vld_q) begin
            if (gnt_q) begin
                move_rsp = ram_rsp;
            end else begin
                host_rsp = ram_rsp;
            end
        end
    end

endmodule

// ==== hdl/line_ram.sv ====
// single-port synchronous line memory with a Wishbone classic slave port

module line_ram
    import rf_types_pkg::*;
    import rf_bus_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    line_t            mem [DEPTH];
    line_t            rd_q;
    logic             ack_q;
    logic             access;
    logic [IDX_W-1:0] idx;

    // a new strobe is taken only while ack is low,
    // so the ack cycle of one access never starts a second one
    assign access = req.cyc && req.stb && !ack_q;

    // out-of-range addresses wrap onto the array
    assign idx = IDX_W'(int'(req.adr) % DEPTH);

    // one-cycle ack, one cycle after the strobe is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // write and registered read share the accepting edge
    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                mem[idx] <= req.dat;
            end
            rd_q <= mem[idx];
        end
    end

    // read data held until the next access
    assign rsp = '{ack: ack_q, dat: rd_q};

endmodule

// ==== hdl/rf_subsystem.sv ====
// line register file top: host port, move engine, arbiter and line memory

module rf_subsystem
    import rf_types_pkg::*;
    import rf_bus_pkg::*;
#(
    parameter int DEPTH = ADDR_SPACE
) (
    input  logic      clk,
    input  logic      rst_n,
    input  wb_req_t   host_req,
    output wb_rsp_t   host_rsp,
    input  logic      move_start,
    input  move_cmd_t move_cmd,
    output logic      move_busy
);

    // engine side of the arbiter
    wb_req_t move_req;
    wb_rsp_t move_rsp;

    // arbiter to memory
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;

    rf_move u_rf_move (
        .clk   (clk),
        .rst_n (rst_n),
        .start (move_start),
        .cmd   (move_cmd),
        .rsp   (move_rsp),
        .busy  (move_busy),
        .req   (move_req)
    );

    // host is master 0, engine is master 1
    bus_arbiter u_bus_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_req (host_req),
        .move_req (move_req),
        .ram_rsp  (ram_rsp),
        .host_rsp (host_rsp),
        .move_rsp (move_rsp),
        .ram_req  (ram_req)
    );

    line_ram #(
        .DEPTH (DEPTH)
    ) u_line_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (ram_req),
        .rsp   (ram_rsp)
    );

endmodule

// ==== rf_move/rf_move.sv ====
// move engine copying runs of lines through the shared Wishbone bus

module rf_move
    import rf_types_pkg::*;
    import rf_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  move_cmd_t cmd,
    input  wb_rsp_t   rsp,
    output logic      busy,
    output wb_req_t   req
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE
    } state_t;

    state_t state_q;
    state_t state_d;

    addr_t  src_q;
    addr_t  dst_q;
    count_t remain_q;
    line_t  buf_q;
    logic   busy_q;
    // low gap after every ack so the host can win the bus
    logic   pause_q;

    logic   accept;
    logic   last_line;
    logic   in_cycle;

    // start pulses during a move are dropped
    assign accept    = start && (state_q == IDLE) && !busy_q;
    assign last_line = (remain_q == count_t'(1));
    assign in_cycle  = (state_q != IDLE) && !pause_q;

    // one read then one write per line
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept && (cmd.count != '0)) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                if (rsp.ack) begin
                    state_d = STORE;
                end
            end
            STORE: begin
                if (rsp.ack) begin
                    state_d = last_line ? IDLE : LOAD;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // zero count gives one busy cycle, since state_d stays IDLE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            busy_q  <= 1'b0;
            pause_q <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q  <= accept || (state_d != IDLE);
            pause_q <= rsp.ack;
        end
    end

    // addresses wrap with the vector width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q    <= '0;
            dst_q    <= '0;
            remain_q <= '0;
        end else if (accept) begin
            src_q    <= cmd.src;
            dst_q    <= cmd.dst;
            remain_q <= cmd.count;
        end else if ((state_q == STORE) && rsp.ack) begin
            src_q    <= src_q + addr_t'(1);
            dst_q    <= dst_q + addr_t'(1);
            remain_q <= remain_q - count_t'(1);
        end
    end

    // line in transit between the read and the write
    always_ff @(posedge clk) begin
        if ((state_q == LOAD) && rsp.ack) begin
            buf_q <= rsp.dat;
        end
    end

    assign req = '{
        cyc: in_cycle,
        stb: in_cycle,
        we:  (state_q == STORE),
        adr: (state_q == STORE) ? dst_q : src_q,
        dat: buf_q
    };

    assign busy = busy_q;

endmodule

// ==== sim.f ====
common/rf_types_pkg.sv
common/rf_bus_pkg.sv
hdl/line_ram.sv
hdl/bus_arbiter.sv
rf_move/rf_move.sv
hdl/rf_subsystem.sv
verif/rf_checker.sv
verif/tb_rf_subsystem.sv

// ==== verif/rf_checker.sv ====
// reference line model, response checks and error counts for the line register file

module rf_checker
    import rf_types_pkg::*;
    import rf_bus_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input wb_req_t   host_req,
    input wb_rsp_t   host_rsp,
    input logic      move_start,
    input move_cmd_t move_cmd,
    input logic      move_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    line_t     model [ADDR_SPACE];
    move_cmd_t pend_cmd;
    logic      busy_seen;
    logic      expect_rise;
    logic      zero_check;
    int        errors = 0;
    int        checks = 0;

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // ascending copy one line at a time so overlaps repeat lines
    task automatic apply_move(input move_cmd_t c);
        addr_t s;
        addr_t d;
        s = c.src;
        d = c.dst;
        for (int i = 0; i < int'(c.count); i++) begin
            model[d] = model[s];
            s = s + addr_t'(1);
            d = d + addr_t'(1);
        end
    endtask

    // sampled mid-cycle away from both clock edges
    always @(negedge clk) begin
        if (!rst_n) begin
            busy_seen   = 1'b0;
            expect_rise = 1'b0;
            zero_check  = 1'b0;
        end else begin
            if (host_rsp.ack) begin
                if (!(host_req.cyc && host_req.stb)) begin
                    report_error("host ack seen while no host request was in flight");
                end else if (host_req.we) begin
                    model[host_req.adr] = host_req.dat;
                end else begin
                    checks++;
                    if (host_rsp.dat !== model[host_req.adr]) begin
                        report_error($sformatf(
                            "mismatch host_rsp.dat at line %02h: expected %016h, actual %016h",
                            host_req.adr, model[host_req.adr], host_rsp.dat));
                    end
                end
            end
            if (expect_rise && !move_busy) begin
                report_error("move_busy did not rise in the cycle after an accepted start");
            end
            if (move_busy && !busy_seen && !expect_rise) begin
                report_error("move_busy rose although no start was accepted");
            end
            if (zero_check && move_busy) begin
                report_error("move_busy stayed high for more than one cycle on a zero-count move");
            end
            zero_check = expect_rise && move_busy && (pend_cmd.count == '0);
            // model catches up in one step when busy falls
            if (busy_seen && !move_busy) begin
                apply_move(pend_cmd);
            end
            // a start while busy is dropped by the engine
            expect_rise = move_start && !move_busy;
            if (expect_rise) begin
                pend_cmd = move_cmd;
            end
            busy_seen = move_busy;
        end
    end

endmodule

// ==== verif/tb_rf_subsystem.sv ====
// testbench top: clock, reset, random stimulus, test sequence and timeout

module tb_rf_subsystem
    import rf_types_pkg::*;
    import rf_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RAND    = 32;
    localparam int MAX_MOVE  = 32;
    localparam int N_BUSY_RD = 6;
    // worst case per test, see the test bodies below
    localparam int HOST_OPS   = ADDR_SPACE + 2 * N_RAND + 9 * MAX_MOVE + 8 + N_BUSY_RD;
    localparam int MOVE_LINES = 5 * MAX_MOVE;
    localparam int TIMEOUT_CYCLES = 8 * HOST_OPS + 8 * MOVE_LINES + 100;

    logic      clk;
    logic      rst_n;
    wb_req_t   host_req;
    wb_rsp_t   host_rsp;
    logic      move_start;
    move_cmd_t move_cmd;
    logic      move_busy;
    int        seed;
    int        cycle_count;
    int        tests_passed;
    int        tests_failed;
    int        seq_errors;

    rf_subsystem #(
        .DEPTH (ADDR_SPACE)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .move_start (move_start),
        .move_cmd   (move_cmd),
        .move_busy  (move_busy)
    );

    rf_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .move_start (move_start),
        .move_cmd   (move_cmd),
        .move_busy  (move_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test sequence never finished", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic line_t rand_line();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int total_errors();
        return chk.errors + seq_errors;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    // one classic cycle, held until ack, then one idle cycle
    task automatic host_access(input logic we, input addr_t adr, input line_t dat);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clk);
        while (!host_rsp.ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        host_req = WB_REQ_IDLE;
        @(posedge clk);
        #1;
    endtask

    task automatic read_run(input addr_t base, input int n);
        for (int i = 0; i < n; i++) begin
            host_access(1'b0, base + addr_t'(i), '0);
        end
    endtask

    task automatic pulse_start(input addr_t src, input addr_t dst, input int n);
        move_cmd   = '{src: src, dst: dst, count: count_t'(n)};
        move_start = 1'b1;
        @(posedge clk);
        #1;
        move_start = 1'b0;
    endtask

    task automatic run_move(input addr_t src, input addr_t dst, input int n);
        pulse_start(src, dst, n);
        while (move_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : run_tests
        addr_t src;
        addr_t dst;
        int    n;
        int    k;
        int    errs;
        addr_t wr_adr [N_RAND];
        seed         = 32'h0c902581;
        tests_passed = 0;
        tests_failed = 0;
        seq_errors   = 0;
        rst_n        = 1'b0;
        host_req     = WB_REQ_IDLE;
        move_start   = 1'b0;
        move_cmd     = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle bus, checker flags any ack or busy
        errs = total_errors();
        repeat (8) @(posedge clk);
        #1;
        report_test("reset idle", errs);

        errs = total_errors();
        for (int i = 0; i < ADDR_SPACE; i++) begin
            host_access(1'b1, addr_t'(i), rand_line());
        end
        for (int i = 0; i < N_RAND; i++) begin
            wr_adr[i] = addr_t'($random(seed));
            host_access(1'b1, wr_adr[i], rand_line());
        end
        for (int i = 0; i < N_RAND; i++) begin
            host_access(1'b0, wr_adr[i], '0);
        end
        report_test("host write and read", errs);

        // destination offset keeps both runs apart modulo 256
        errs = total_errors();
        n    = 1 + int'($unsigned($random(seed)) % MAX_MOVE);
        src  = addr_t'($random(seed));
        dst  = src + addr_t'(n + int'($unsigned($random(seed)) % (ADDR_SPACE - 2 * n + 1)));
        run_move(src, dst, n);
        read_run(dst, n);
        read_run(src, n);
        report_test("disjoint move", errs);

        // both runs cross line 255
        errs = total_errors();
        n    = 8 + int'($unsigned($random(seed)) % (MAX_MOVE - 8));
        k    = 1 + int'($unsigned($random(seed)) % (n - 1));
        src  = addr_t'(ADDR_SPACE - 1 - int'($unsigned($random(seed)) % 4));
        run_move(src, src + addr_t'(k), n);
        read_run(src, n + k);
        src  = addr_t'($unsigned($random(seed)) % 4);
        dst  = src - addr_t'(k);
        run_move(src, dst, n);
        read_run(dst, n + k);
        report_test("overlapping moves", errs);

        errs = total_errors();
        src  = addr_t'($random(seed));
        dst  = addr_t'($random(seed));
        run_move(src, dst, 0);
        read_run(src, 4);
        read_run(dst, 4);
        src  = addr_t'($random(seed));
        dst  = src + addr_t'(8'h40);
        pulse_start(src, dst, 16);
        repeat (3) @(posedge clk);
        #1;
        // would overwrite the source run if taken
        pulse_start(src + addr_t'(8'h80), src, 16);
        while (move_busy) begin
            @(posedge clk);
            #1;
        end
        read_run(src, 16);
        read_run(dst, 16);
        report_test("zero count and start while busy", errs);

        errs = total_errors();
        n    = 24;
        src  = addr_t'($random(seed));
        dst  = src + addr_t'(8'h80);
        pulse_start(src, dst, n);
        for (int i = 0; i < N_BUSY_RD; i++) begin
            if (!move_busy) begin
                $display("host read %0d was issued after the move had already finished", i);
                seq_errors++;
            end
            k = n + int'($unsigned($random(seed)) % (ADDR_SPACE - n));
            host_access(1'b0, dst + addr_t'(k), '0);
        end
        while (move_busy) begin
            @(posedge clk);
            #1;
        end
        read_run(dst, n);
        report_test("host reads during move", errs);

        $display("tests passed: %0d, tests failed: %0d, host reads compared: %0d",
                 tests_passed, tests_failed, chk.checks);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
